//--- logic/ldu_pkg.sv
// --------------------------------------------------------------------------
// queue depth must stay a power of two since index arithmetic wraps by width
// --------------------------------------------------------------------------

package ldu_pkg;

    localparam int LDU_CQ_ENTRIES     = 8;
    localparam int LOG_LDU_CQ_ENTRIES = 3;
    localparam int LOG_ROB_ENTRIES    = 6;
    localparam int LOG_PR_COUNT       = 6;

    typedef logic [LOG_LDU_CQ_ENTRIES-1:0] cq_index_t;
    typedef logic [LOG_ROB_ENTRIES-1:0]    rob_index_t;
    typedef logic [LOG_PR_COUNT-1:0]       pr_t;
    typedef logic [3:0]                    ld_op_t;

    // load op codes in funct3 style
    localparam ld_op_t LD_OP_LB  = 4'b0000;
    localparam ld_op_t LD_OP_LH  = 4'b0001;
    localparam ld_op_t LD_OP_LW  = 4'b0010;
    localparam ld_op_t LD_OP_LBU = 4'b0100;
    localparam ld_op_t LD_OP_LHU = 4'b0101;

    typedef struct packed {
        logic       valid;
        logic       killed;
        logic       data_ready;
        logic       wb_sent;
        logic       committed;
        ld_op_t     op;
        pr_t        dest_pr;
        rob_index_t rob_index;
        logic [31:0] data;
    } cq_entry_t;

endpackage

//--- logic/ldu_cq_sched_if.sv
// --------------------------------------------------------------------------
// lookup fields are combinational reads of the entry at lookup_index
// --------------------------------------------------------------------------

`timescale 1ns/1ps

interface ldu_cq_sched_if;

    import ldu_pkg::*;

    // storage side status
    logic [LDU_CQ_ENTRIES-1:0] ready_mask;
    cq_index_t                 head_ptr;

    // chosen entry held until the writeback ack
    logic      pick_valid;
    cq_index_t pick_index;
    logic      wb_done;

    // entry lookup for the candidate pick
    cq_index_t   lookup_index;
    pr_t         lookup_dest_pr;
    rob_index_t  lookup_rob_index;
    logic [31:0] lookup_data;

    modport store (
        output ready_mask, head_ptr,
        output lookup_dest_pr, lookup_rob_index, lookup_data,
        input  pick_valid, pick_index, wb_done, lookup_index
    );

    modport sched (
        input  ready_mask, head_ptr,
        input  lookup_dest_pr, lookup_rob_index, lookup_data,
        output pick_valid, pick_index, wb_done, lookup_index
    );

endinterface

//--- logic/ldu_cq.sv
// --------------------------------------------------------------------------
// commit strobe is compared against the head entry only
// dcache word is assumed naturally aligned, sub-word loads use the low bytes
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ldu_cq (
    input  logic                clk,
    input  logic                rst,

    // enqueue from dispatch
    input  logic                enq_valid,
    input  ldu_pkg::ld_op_t     enq_op,
    input  ldu_pkg::pr_t        enq_dest_pr,
    input  ldu_pkg::rob_index_t enq_rob_index,
    output logic                enq_ready,

    // dcache data return
    input  logic                dcache_resp_valid,
    input  ldu_pkg::cq_index_t  dcache_resp_cq_index,
    input  logic [31:0]         dcache_resp_data,

    // ROB commit and kill
    input  logic                rob_commit_valid,
    input  ldu_pkg::rob_index_t rob_commit_index,
    input  logic                rob_kill_valid,
    input  ldu_pkg::rob_index_t rob_kill_abs_head_index,
    input  ldu_pkg::rob_index_t rob_kill_rel_kill_younger_index,

    ldu_cq_sched_if.store       sched
);

    import ldu_pkg::*;

    // ----------------------------------------------------------------------
    // state

    cq_entry_t [LDU_CQ_ENTRIES-1:0] entry_array;

    cq_index_t enq_ptr, enq_ptr_plus_1;
    cq_index_t deq_ptr, deq_ptr_plus_1;

    cq_entry_t head;
    logic      full;
    logic      enq_fire;
    logic      commit_match;
    logic      head_in_flight;
    logic      head_retire;

    // ----------------------------------------------------------------------
    // helpers

    // strictly past the kill point when taken relative to the kill head
    function automatic logic is_younger(rob_index_t idx);
        rob_index_t rel;
        rel = idx - rob_kill_abs_head_index;
        return rel > rob_kill_rel_kill_younger_index;
    endfunction

    function automatic logic [31:0] format_data(ld_op_t op, logic [31:0] word);
        case (op)
            LD_OP_LB:  return {{24{word[7]}}, word[7:0]};
            LD_OP_LH:  return {{16{word[15]}}, word[15:0]};
            LD_OP_LBU: return {24'h0, word[7:0]};
            LD_OP_LHU: return {16'h0, word[15:0]};
            LD_OP_LW:  return word;
            default:   return word;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // pointers and head status

    assign enq_ptr_plus_1 = enq_ptr + 1'b1;
    assign deq_ptr_plus_1 = deq_ptr + 1'b1;

    assign head = entry_array[deq_ptr];

    // equal pointers with a live head means every slot is taken
    assign full      = (enq_ptr == deq_ptr) && head.valid;
    assign enq_ready = !full;
    assign enq_fire  = enq_valid && enq_ready;

    assign commit_match = rob_commit_valid && head.valid && !head.killed
                          && (head.rob_index == rob_commit_index);

    // a killed head still on the data try port waits for its ack
    assign head_in_flight = sched.pick_valid && (sched.pick_index == deq_ptr);

    always_comb begin
        head_retire = 1'b0;
        if (head.valid) begin
            if (head.killed)
                head_retire = !head_in_flight;
            else
                head_retire = head.wb_sent && (head.committed || commit_match);
        end
    end

    // ----------------------------------------------------------------------
    // scheduler view

    always_comb begin
        for (int i = 0; i < LDU_CQ_ENTRIES; i++) begin
            sched.ready_mask[i] = entry_array[i].valid && entry_array[i].data_ready
                                  && !entry_array[i].killed && !entry_array[i].wb_sent;
        end
    end

    assign sched.head_ptr         = deq_ptr;
    assign sched.lookup_dest_pr   = entry_array[sched.lookup_index].dest_pr;
    assign sched.lookup_rob_index = entry_array[sched.lookup_index].rob_index;
    assign sched.lookup_data      = entry_array[sched.lookup_index].data;

    // ----------------------------------------------------------------------
    // entry updates

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LDU_CQ_ENTRIES; i++) begin
                entry_array[i].valid      <= 1'b0;
                entry_array[i].killed     <= 1'b0;
                entry_array[i].data_ready <= 1'b0;
                entry_array[i].wb_sent    <= 1'b0;
                entry_array[i].committed  <= 1'b0;
            end
            enq_ptr <= '0;
            deq_ptr <= '0;
        end else begin
            // kill marks younger live entries
            if (rob_kill_valid) begin
                for (int i = 0; i < LDU_CQ_ENTRIES; i++) begin
                    if (entry_array[i].valid && is_younger(entry_array[i].rob_index))
                        entry_array[i].killed <= 1'b1;
                end
            end

            // data fill formatted by load op
            if (dcache_resp_valid && entry_array[dcache_resp_cq_index].valid) begin
                entry_array[dcache_resp_cq_index].data <=
                    format_data(entry_array[dcache_resp_cq_index].op, dcache_resp_data);
                entry_array[dcache_resp_cq_index].data_ready <= 1'b1;
            end

            if (sched.wb_done)
                entry_array[sched.pick_index].wb_sent <= 1'b1;

            // commit may land before writeback
            if (commit_match)
                entry_array[deq_ptr].committed <= 1'b1;

            if (enq_fire) begin
                entry_array[enq_ptr] <= '{
                    valid:      1'b1,
                    killed:     rob_kill_valid && is_younger(enq_rob_index),
                    data_ready: 1'b0,
                    wb_sent:    1'b0,
                    committed:  1'b0,
                    op:         enq_op,
                    dest_pr:    enq_dest_pr,
                    rob_index:  enq_rob_index,
                    data:       '0
                };
                enq_ptr <= enq_ptr_plus_1;
            end

            if (head_retire) begin
                entry_array[deq_ptr].valid <= 1'b0;
                deq_ptr <= deq_ptr_plus_1;
            end
        end
    end

endmodule

//--- logic/ldu_cq_sched.sv
// --------------------------------------------------------------------------
// one offer at a time and a new pick only while the port is idle
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ldu_cq_sched (
    input  logic                clk,
    input  logic                rst,

    ldu_cq_sched_if.sched       sched,

    // data try to writeback
    output logic                data_try_valid,
    output logic [31:0]         data_try_data,
    output ldu_pkg::pr_t        data_try_dest_pr,
    output ldu_pkg::rob_index_t data_try_rob_index,
    output ldu_pkg::cq_index_t  data_try_cq_index,
    input  logic                data_try_ack
);

    import ldu_pkg::*;

    logic [2*LDU_CQ_ENTRIES-1:0] mask_twice;
    logic [LDU_CQ_ENTRIES-1:0]   rotated;
    logic                        cand_found;
    cq_index_t                   cand_offset;

    logic      busy;
    cq_index_t busy_index;

    // ----------------------------------------------------------------------
    // oldest-first pick with the head at bit 0 of rotated

    assign mask_twice = {sched.ready_mask, sched.ready_mask};
    assign rotated    = mask_twice[sched.head_ptr +: LDU_CQ_ENTRIES];

    always_comb begin
        cand_found  = 1'b0;
        cand_offset = '0;
        // downward scan so the lowest set bit wins
        for (int i = LDU_CQ_ENTRIES - 1; i >= 0; i--) begin
            if (rotated[i]) begin
                cand_found  = 1'b1;
                cand_offset = cq_index_t'(i);
            end
        end
    end

    assign sched.lookup_index = sched.head_ptr + cand_offset;

    // ----------------------------------------------------------------------
    // port register

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            busy_index <= '0;
        end else if (busy) begin
            if (data_try_ack)
                busy <= 1'b0;
        end else if (cand_found) begin
            busy       <= 1'b1;
            busy_index <= sched.lookup_index;
        end
    end

    // payload captured with the pick and held through back-pressure
    always_ff @(posedge clk) begin
        if (!busy && cand_found) begin
            data_try_data      <= sched.lookup_data;
            data_try_dest_pr   <= sched.lookup_dest_pr;
            data_try_rob_index <= sched.lookup_rob_index;
        end
    end

    assign data_try_valid    = busy;
    assign data_try_cq_index = busy_index;

    assign sched.pick_valid = busy;
    assign sched.pick_index = busy_index;
    assign sched.wb_done    = busy && data_try_ack;

endmodule

//--- logic/ldu_cq_top.sv
// --------------------------------------------------------------------------
// commit and kill inputs are single-cycle strobes and dcache return has no stall
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ldu_cq_top (
    input  logic                clk,
    input  logic                rst,

    // enqueue
    input  logic                enq_valid,
    input  ldu_pkg::ld_op_t     enq_op,
    input  ldu_pkg::pr_t        enq_dest_pr,
    input  ldu_pkg::rob_index_t enq_rob_index,
    output logic                enq_ready,

    // dcache data return
    input  logic                dcache_resp_valid,
    input  ldu_pkg::cq_index_t  dcache_resp_cq_index,
    input  logic [31:0]         dcache_resp_data,

    // data try
    output logic                data_try_valid,
    output logic [31:0]         data_try_data,
    output ldu_pkg::pr_t        data_try_dest_pr,
    output ldu_pkg::rob_index_t data_try_rob_index,
    output ldu_pkg::cq_index_t  data_try_cq_index,
    input  logic                data_try_ack,

    // ROB commit and kill
    input  logic                rob_commit_valid,
    input  ldu_pkg::rob_index_t rob_commit_index,
    input  logic                rob_kill_valid,
    input  ldu_pkg::rob_index_t rob_kill_abs_head_index,
    input  ldu_pkg::rob_index_t rob_kill_rel_kill_younger_index
);

    ldu_cq_sched_if sched_if ();

    ldu_cq storage (
        .clk                             (clk),
        .rst                             (rst),
        .enq_valid                       (enq_valid),
        .enq_op                          (enq_op),
        .enq_dest_pr                     (enq_dest_pr),
        .enq_rob_index                   (enq_rob_index),
        .enq_ready                       (enq_ready),
        .dcache_resp_valid               (dcache_resp_valid),
        .dcache_resp_cq_index            (dcache_resp_cq_index),
        .dcache_resp_data                (dcache_resp_data),
        .rob_commit_valid                (rob_commit_valid),
        .rob_commit_index                (rob_commit_index),
        .rob_kill_valid                  (rob_kill_valid),
        .rob_kill_abs_head_index         (rob_kill_abs_head_index),
        .rob_kill_rel_kill_younger_index (rob_kill_rel_kill_younger_index),
        .sched                           (sched_if.store)
    );

    ldu_cq_sched scheduler (
        .clk                (clk),
        .rst                (rst),
        .sched              (sched_if.sched),
        .data_try_valid     (data_try_valid),
        .data_try_data      (data_try_data),
        .data_try_dest_pr   (data_try_dest_pr),
        .data_try_rob_index (data_try_rob_index),
        .data_try_cq_index  (data_try_cq_index),
        .data_try_ack       (data_try_ack)
    );

endmodule

//--- test/ldu_cq_props.sv
// --------------------------------------------------------------------------
// watches only the data try port on the scheduler clock
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ldu_cq_props (
    input logic                clk,
    input logic                rst,
    input logic                data_try_valid,
    input logic                data_try_ack,
    input logic [31:0]         data_try_data,
    input ldu_pkg::pr_t        data_try_dest_pr,
    input ldu_pkg::rob_index_t data_try_rob_index,
    input ldu_pkg::cq_index_t  data_try_cq_index
);

    // offer and payload held until the ack edge
    offer_held: assert property (
        @(posedge clk) disable iff (rst)
        data_try_valid && !data_try_ack |=> data_try_valid
            && $stable(data_try_data) && $stable(data_try_dest_pr)
            && $stable(data_try_rob_index) && $stable(data_try_cq_index)
    ) else $error("data try offer changed before its ack");

    // port stays idle through reset
    idle_in_reset: assert property (
        @(posedge clk) rst |=> !data_try_valid
    ) else $error("data_try_valid raised during reset");

    // one idle cycle after every ack
    drop_after_ack: assert property (
        @(posedge clk) disable iff (rst)
        data_try_valid && data_try_ack |=> !data_try_valid
    ) else $error("data_try_valid still high in the cycle after an ack");

endmodule

//--- test/ldu_cq_tb.sv
// --------------------------------------------------------------------------
// runs from the project root and reads test/ldu_cq_trace.txt
// all loads in the trace are LW
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ldu_cq_tb;

    import ldu_pkg::*;

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        rob_index_t rob;
        cq_index_t  slot;
        logic       killed;
        logic       sent;
        logic       committed;
    } model_entry_t;

    logic        clk;
    logic        rst;
    logic        enq_valid;
    ld_op_t      enq_op;
    pr_t         enq_dest_pr;
    rob_index_t  enq_rob_index;
    logic        enq_ready;
    logic        dcache_resp_valid;
    cq_index_t   dcache_resp_cq_index;
    logic [31:0] dcache_resp_data;
    logic        data_try_valid;
    logic [31:0] data_try_data;
    pr_t         data_try_dest_pr;
    rob_index_t  data_try_rob_index;
    cq_index_t   data_try_cq_index;
    logic        data_try_ack;
    logic        rob_commit_valid;
    rob_index_t  rob_commit_index;
    logic        rob_kill_valid;
    rob_index_t  rob_kill_abs_head_index;
    rob_index_t  rob_kill_rel_kill_younger_index;

    // reference queue with the oldest load at index 0
    model_entry_t model_q[$];
    // slot that the next enqueue takes in the circular queue
    cq_index_t    model_tail;

    int seed;
    int hold_max;
    int line_no;

    ldu_cq_top uut (
        .clk                             (clk),
        .rst                             (rst),
        .enq_valid                       (enq_valid),
        .enq_op                          (enq_op),
        .enq_dest_pr                     (enq_dest_pr),
        .enq_rob_index                   (enq_rob_index),
        .enq_ready                       (enq_ready),
        .dcache_resp_valid               (dcache_resp_valid),
        .dcache_resp_cq_index            (dcache_resp_cq_index),
        .dcache_resp_data                (dcache_resp_data),
        .data_try_valid                  (data_try_valid),
        .data_try_data                   (data_try_data),
        .data_try_dest_pr                (data_try_dest_pr),
        .data_try_rob_index              (data_try_rob_index),
        .data_try_cq_index               (data_try_cq_index),
        .data_try_ack                    (data_try_ack),
        .rob_commit_valid                (rob_commit_valid),
        .rob_commit_index                (rob_commit_index),
        .rob_kill_valid                  (rob_kill_valid),
        .rob_kill_abs_head_index         (rob_kill_abs_head_index),
        .rob_kill_rel_kill_younger_index (rob_kill_rel_kill_younger_index)
    );

    bind ldu_cq_sched ldu_cq_props port_checks (
        .clk                (clk),
        .rst                (rst),
        .data_try_valid     (data_try_valid),
        .data_try_ack       (data_try_ack),
        .data_try_data      (data_try_data),
        .data_try_dest_pr   (data_try_dest_pr),
        .data_try_rob_index (data_try_rob_index),
        .data_try_cq_index  (data_try_cq_index)
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------------------
    // reporting and compares

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic string at_line(input string what);
        return $sformatf("line %0d %s", line_no, what);
    endfunction

    task automatic check_pr(input string name, input pr_t exp, input pr_t act);
        if (act !== exp)
            fail_now($sformatf("Mismatch %s: expected %0h, actual %0h", name, exp, act));
    endtask

    task automatic check_rob(input string name, input rob_index_t exp, input rob_index_t act);
        if (act !== exp)
            fail_now($sformatf("Mismatch %s: expected %0h, actual %0h", name, exp, act));
    endtask

    task automatic check_index(input string name, input cq_index_t exp, input cq_index_t act);
        if (act !== exp)
            fail_now($sformatf("Mismatch %s: expected %0h, actual %0h", name, exp, act));
    endtask

    task automatic check_data(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp)
            fail_now($sformatf("Mismatch %s: expected %08h, actual %08h", name, exp, act));
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_now($sformatf("Mismatch %s: expected %0b, actual %0b", name, exp, act));
    endtask

    // ----------------------------------------------------------------------
    // reference queue

    function automatic int find_in_model(input rob_index_t rob);
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].rob == rob)
                return i;
        end
        return -1;
    endfunction

    // killed heads leave alone while live heads need writeback and commit
    task automatic retire_model_head();
        while (model_q.size() > 0 && (model_q[0].killed
               || (model_q[0].sent && model_q[0].committed)))
            void'(model_q.pop_front());
    endtask

    task automatic mark_killed(input rob_index_t abs_head, input rob_index_t rel);
        model_entry_t e;
        for (int i = 0; i < model_q.size(); i++) begin
            e = model_q[i];
            if (rob_index_t'(e.rob - abs_head) > rel)
                e.killed = 1'b1;
            model_q[i] = e;
        end
    endtask

    // ----------------------------------------------------------------------
    // bus actions driven 2 ns after the edge

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic enqueue(input ld_op_t op, input pr_t pr, input rob_index_t rob);
        model_entry_t e;
        check_ready(at_line("enq_ready"), model_q.size() < LDU_CQ_ENTRIES, enq_ready);
        enq_valid     = 1'b1;
        enq_op        = op;
        enq_dest_pr   = pr;
        enq_rob_index = rob;
        next_cycle();
        enq_valid = 1'b0;
        e = '0;
        e.rob = rob;
        e.slot = model_tail;
        model_tail = model_tail + 1'b1;
        model_q.push_back(e);
    endtask

    task automatic send_response(input cq_index_t idx, input logic [31:0] data);
        dcache_resp_valid    = 1'b1;
        dcache_resp_cq_index = idx;
        dcache_resp_data     = data;
        next_cycle();
        dcache_resp_valid = 1'b0;
    endtask

    task automatic send_commit(input rob_index_t rob);
        model_entry_t e;
        rob_commit_valid = 1'b1;
        rob_commit_index = rob;
        next_cycle();
        rob_commit_valid = 1'b0;
        if (model_q.size() > 0 && !model_q[0].killed && model_q[0].rob == rob) begin
            e = model_q[0];
            e.committed = 1'b1;
            model_q[0] = e;
        end
        retire_model_head();
    endtask

    task automatic send_kill(input rob_index_t abs_head, input rob_index_t rel);
        rob_kill_valid                  = 1'b1;
        rob_kill_abs_head_index         = abs_head;
        rob_kill_rel_kill_younger_index = rel;
        next_cycle();
        rob_kill_valid = 1'b0;
        mark_killed(abs_head, rel);
        retire_model_head();
    endtask

    task automatic check_offer(input logic [31:0] data, input pr_t pr, input rob_index_t rob,
                               input cq_index_t slot);
        check_data(at_line("data_try_data"), data, data_try_data);
        check_pr(at_line("data_try_dest_pr"), pr, data_try_dest_pr);
        check_rob(at_line("data_try_rob_index"), rob, data_try_rob_index);
        check_index(at_line("data_try_cq_index"), slot, data_try_cq_index);
    endtask

    // wait for an offer and ack it after a random stall
    task automatic take_writeback(input logic [31:0] data, input pr_t pr,
                                  input rob_index_t rob);
        int waited;
        int stall;
        int idx;
        model_entry_t e;
        waited = 0;
        while (!data_try_valid && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!data_try_valid)
            fail_now($sformatf("line %0d: no writeback offer within %0d cycles",
                               line_no, WAIT_LIMIT));
        idx = find_in_model(rob);
        if (idx < 0)
            fail_now($sformatf("line %0d: writeback for a load the queue does not hold",
                               line_no));
        e = model_q[idx];
        check_offer(data, pr, rob, e.slot);
        stall = 0;
        if (hold_max > 0)
            stall = 1 + ($unsigned($random(seed)) % hold_max);
        for (int i = 0; i < stall; i++) begin
            next_cycle();
            check_ready(at_line("data_try_valid held"), 1'b1, data_try_valid);
            check_offer(data, pr, rob, e.slot);
        end
        data_try_ack = 1'b1;
        next_cycle();
        data_try_ack = 1'b0;
        check_ready(at_line("data_try_valid after ack"), 1'b0, data_try_valid);
        e.sent = 1'b1;
        model_q[idx] = e;
        retire_model_head();
    endtask

    // ----------------------------------------------------------------------
    // trace player

    initial begin
        int fd;
        string line;
        string args;
        byte cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        clk = 1'b0;
        rst = 1'b1;
        enq_valid = 1'b0;
        enq_op = '0;
        enq_dest_pr = '0;
        enq_rob_index = '0;
        dcache_resp_valid = 1'b0;
        dcache_resp_cq_index = '0;
        dcache_resp_data = '0;
        data_try_ack = 1'b0;
        rob_commit_valid = 1'b0;
        rob_commit_index = '0;
        rob_kill_valid = 1'b0;
        rob_kill_abs_head_index = '0;
        rob_kill_rel_kill_younger_index = '0;
        model_tail = '0;
        seed = 18682;
        hold_max = 0;
        line_no = 0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        fd = $fopen("test/ldu_cq_trace.txt", "r");
        if (fd == 0)
            fail_now("could not open the trace file test/ldu_cq_trace.txt");
        while ($fgets(line, fd) > 0) begin
            line_no++;
            cmd = line.getc(0);
            args = line.substr(1, line.len() - 1);
            a = '0;
            b = '0;
            c = '0;
            void'($sscanf(args, "%h %h %h", a, b, c));
            case (cmd)
                "E": enqueue(ld_op_t'(a), pr_t'(b), rob_index_t'(c));
                "R": send_response(cq_index_t'(a), b);
                "W": take_writeback(a, pr_t'(b), rob_index_t'(c));
                "C": send_commit(rob_index_t'(a));
                "K": send_kill(rob_index_t'(a), rob_index_t'(b));
                "H": hold_max = int'(a);
                "I": repeat (int'(a)) next_cycle();
                "N": begin
                    for (int i = 0; i < int'(a); i++) begin
                        next_cycle();
                        check_ready(at_line("data_try_valid idle"), 1'b0, data_try_valid);
                    end
                end
                "Y": check_ready(at_line("enq_ready"), model_q.size() < LDU_CQ_ENTRIES,
                                 enq_ready);
                "#", " ", "\n", "\r": ;
                default: fail_now($sformatf("line %0d: unknown trace command", line_no));
            endcase
        end
        $fclose(fd);
        $display("No errors");
        $finish;
    end

endmodule

//--- project.f
logic/ldu_pkg.sv
logic/ldu_cq_sched_if.sv
logic/ldu_cq.sv
logic/ldu_cq_sched.sv
logic/ldu_cq_top.sv
test/ldu_cq_props.sv
test/ldu_cq_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the load queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ldu_cq_tb \
    -Mdir obj_dir -f project.f || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vldu_cq_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "No errors" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/ldu_cq_trace.txt
# E op dest_pr rob | R cq_index data | W data dest_pr rob | C rob | K abs_head rel
# H max_ack_stall | I idle_cycles | N cycles_without_offer | Y enq_ready check, all hex
E 2 01 00
E 2 02 01
E 2 03 02
E 2 04 03
E 2 05 04
E 2 06 05
E 2 07 06
E 2 08 07
Y
# out of order data, slot 3 alone when the pick is taken
H 3
R 3 c0de0003
R 5 c0de0005
R 1 c0de0001
W c0de0003 04 03
W c0de0001 02 01
W c0de0005 06 05
R 0 c0de0000
W c0de0000 01 00
# commit that misses the head
C 05
I 2
Y
C 00
Y
C 01
# commit before writeback
C 02
R 2 c0de0002
W c0de0002 03 02
I 3
Y
C 03
E 2 09 08
E 2 0a 09
E 2 0b 0a
E 2 0c 0b
Y
# kill everything past rob 05
K 04 01
R 6 dead0006
R 1 dead0009
N a
R 4 c0de0004
W c0de0004 05 04
C 04
C 05
I a
Y
# second lap, pointers wrap from slot 7 to slot 0
E 2 10 06
E 2 11 07
E 2 12 08
E 2 13 09
E 2 14 0a
E 2 15 0b
E 2 16 0c
E 2 17 0d
Y
H 2
R 7 a7a7a7a7
R 4 a4a4a4a4
R 2 a2a2a2a2
W a7a7a7a7 13 09
W a4a4a4a4 10 06
W a2a2a2a2 16 0c
C 09
I 2
Y
C 06
Y
C 07
R 5 a5a5a5a5
W a5a5a5a5 11 07
I 3
Y
